/* all.f */
sr_types_pkg.sv
aos_map_pkg.sv
axil_sr_bridge.sv
sr_pipe.sv
sr_router.sv
sr_config_regs.sv
app_scratch.sv
aos_softreg_top.sv
tb_clock_gen.sv
aos_softreg_tb.sv

/* aos_softreg_tb.sv */
/*
 * Testbench for the soft-register subsystem
 * Drives the AXI4-Lite port with LFSR-driven accesses and stalls, keeps a
 * model of every slot and the enable mask, and compares each response.
 */

`timescale 1ns/1ps

module aos_softreg_tb;

	localparam int NUM_APPS     = 4;
	localparam int PIPE_STAGES  = 2;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_WORDS    = 4;
	localparam int NUM_RAND     = 40;

	// Reset reads, random pairs, disable test, configuration test
	localparam int NUM_TXN     = (NUM_APPS * NUM_WORDS + 1) + 2 * NUM_RAND + 11 + 14;
	localparam int CYCLE_LIMIT = NUM_TXN * 40 + RESET_CYCLES;

	logic                   global_clk;
	logic                   rst_n;
	logic                   awvalid;
	logic [31:0]            awaddr;
	logic                   awready;
	logic                   wvalid;
	logic [31:0]            wdata;
	logic [3:0]             wstrb;
	logic                   wready;
	logic                   bvalid;
	aos_map_pkg::axi_resp_e bresp;
	logic                   bready;
	logic                   arvalid;
	logic [31:0]            araddr;
	logic                   arready;
	logic                   rvalid;
	logic [31:0]            rdata;
	aos_map_pkg::axi_resp_e rresp;
	logic                   rready;

	// Model state
	sr_types_pkg::sr_data_t model_words [aos_map_pkg::MAX_APPS][NUM_WORDS];
	logic [NUM_APPS-1:0]    model_mask;

	logic [31:0] lfsr_state;
	int          cycle_count;
	int          data_errors;
	int          resp_errors;
	int          protocol_errors;

	tb_clock_gen #(
		.PERIOD_NS    (40),
		.RESET_CYCLES (RESET_CYCLES)
	) tb_clock_gen_inst (
		.global_clk (global_clk),
		.rst_n      (rst_n)
	);

	aos_softreg_top #(
		.NUM_APPS    (NUM_APPS),
		.PIPE_STAGES (PIPE_STAGES)
	) aos_softreg_top_inst (
		.global_clk (global_clk),
		.rst_n      (rst_n),
		.awvalid    (awvalid),
		.awaddr     (awaddr),
		.awready    (awready),
		.wvalid     (wvalid),
		.wdata      (wdata),
		.wstrb      (wstrb),
		.wready     (wready),
		.bvalid     (bvalid),
		.bresp      (bresp),
		.bready     (bready),
		.arvalid    (arvalid),
		.araddr     (araddr),
		.arready    (arready),
		.rvalid     (rvalid),
		.rdata      (rdata),
		.rresp      (rresp),
		.rready     (rready)
	);

	// --------------------
	// Random source
	// --------------------
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int b = 0; b < n; b++) begin
			if (lfsr_state[0])
				lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
			else
				lfsr_state = lfsr_state >> 1;
			val = {val[30:0], lfsr_state[0]};
		end
		return val;
	endfunction

	function automatic logic rand_bit();
		logic [31:0] v;
		v = take_bits(1);
		return v[0];
	endfunction

	function automatic sr_types_pkg::sr_addr_t make_addr(input logic cfg, input int app,
	                                                     input int idx);
		sr_types_pkg::sr_addr_t a;
		a = '0;
		a[aos_map_pkg::CFG_SEL_BIT] = cfg;
		a[aos_map_pkg::APP_SEL_LSB +: aos_map_pkg::APP_SEL_W] = app[aos_map_pkg::APP_SEL_W-1:0];
		a[aos_map_pkg::REG_IDX_LSB +: aos_map_pkg::REG_IDX_W] = idx[aos_map_pkg::REG_IDX_W-1:0];
		return a;
	endfunction

	// --------------------
	// Reference model
	// --------------------
	function automatic void model_write(input sr_types_pkg::sr_addr_t addr,
	                                    input sr_types_pkg::sr_data_t data);
		int app;
		int idx;
		app = addr[aos_map_pkg::APP_SEL_LSB +: aos_map_pkg::APP_SEL_W];
		idx = addr[aos_map_pkg::REG_IDX_LSB +: aos_map_pkg::REG_IDX_W];
		if (addr[aos_map_pkg::CFG_SEL_BIT]) begin
			if (idx == 0)
				model_mask = data[NUM_APPS-1:0];
		end else if ((app < NUM_APPS) && model_mask[app]) begin
			model_words[app][idx] = data;
		end
	endfunction

	function automatic sr_types_pkg::sr_data_t model_read(input sr_types_pkg::sr_addr_t addr);
		int app;
		int idx;
		sr_types_pkg::sr_data_t result;
		app = addr[aos_map_pkg::APP_SEL_LSB +: aos_map_pkg::APP_SEL_W];
		idx = addr[aos_map_pkg::REG_IDX_LSB +: aos_map_pkg::REG_IDX_W];
		result = '0;
		if (addr[aos_map_pkg::CFG_SEL_BIT]) begin
			if (idx == 0)
				result[NUM_APPS-1:0] = model_mask;
		end else if ((app < NUM_APPS) && model_mask[app]) begin
			result = model_words[app][idx];
		end
		return result;
	endfunction

	// --------------------
	// Compare tasks
	// --------------------
	task automatic check_data(input string sig, input sr_types_pkg::sr_data_t got,
	                          input sr_types_pkg::sr_data_t exp);
		if (got !== exp) begin
			data_errors++;
			$display("Error: %s = 0x%08h, expected 0x%08h at %0t", sig, got, exp, $time);
		end
	endtask

	task automatic check_resp(input string sig, input aos_map_pkg::axi_resp_e got,
	                          input aos_map_pkg::axi_resp_e exp);
		if (got !== exp) begin
			resp_errors++;
			$display("Error: %s = 0x%0h, expected 0x%0h at %0t", sig, got, exp, $time);
		end
	endtask

	task automatic flag_protocol(input string what);
		protocol_errors++;
		$display("Protocol failure at %0t: %s", $time, what);
	endtask

	// --------------------
	// AXI4-Lite accesses
	// --------------------
	task automatic axil_write(input sr_types_pkg::sr_addr_t addr,
	                          input sr_types_pkg::sr_data_t data);
		int  aw_delay;
		int  w_delay;
		int  cyc;
		bit  aw_done;
		bit  w_done;
		aw_delay = take_bits(2);
		w_delay  = take_bits(2);
		cyc      = 0;
		aw_done  = 1'b0;
		w_done   = 1'b0;
		wstrb   <= 4'(take_bits(4));
		while (!(aw_done && w_done)) begin
			awvalid <= !aw_done && (cyc >= aw_delay);
			awaddr  <= addr;
			wvalid  <= !w_done && (cyc >= w_delay);
			wdata   <= data;
			@(posedge global_clk);
			if (aw_done && awready)
				flag_protocol("awready stayed high after the AW transfer");
			if (w_done && wready)
				flag_protocol("wready stayed high after the W transfer");
			if ((aw_done || w_done) && arready)
				flag_protocol("arready high while a write was being collected");
			if (awvalid && awready)
				aw_done = 1'b1;
			if (wvalid && wready)
				w_done = 1'b1;
			cyc++;
		end
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		bready  <= rand_bit();
		model_write(addr, data);

		// B phase with random stalls
		@(posedge global_clk);
		if (!bvalid)
			flag_protocol("bvalid did not rise the cycle after AW and W arrived");
		while (!(bvalid && bready)) begin
			if (bvalid && (awready || wready || arready))
				flag_protocol("a ready was high while the write response was pending");
			bready <= rand_bit();
			@(posedge global_clk);
		end
		check_resp("bresp", bresp, aos_map_pkg::resp_okay);
		if (awready || wready || arready)
			flag_protocol("a ready was high in the cycle of the B transfer");
		bready <= 1'b0;
	endtask

	task automatic axil_read(input sr_types_pkg::sr_addr_t addr,
	                         output sr_types_pkg::sr_data_t data);
		sr_types_pkg::sr_data_t held;
		bit                     seen;
		seen     = 1'b0;
		held     = '0;
		araddr  <= addr;
		arvalid <= 1'b1;
		rready  <= rand_bit();
		@(posedge global_clk);
		while (!arready) begin
			rready <= rand_bit();
			@(posedge global_clk);
		end
		arvalid <= 1'b0;
		rready  <= rand_bit();
		@(posedge global_clk);

		// Data must hold through R stalls
		while (!(rvalid && rready)) begin
			if (awready || wready || arready)
				flag_protocol("a ready was high while the read was in progress");
			if (rvalid) begin
				if (!seen) begin
					held = rdata;
					seen = 1'b1;
				end else begin
					check_data("rdata (stalled)", rdata, held);
				end
			end
			rready <= rand_bit();
			@(posedge global_clk);
		end
		if (seen)
			check_data("rdata (stalled)", rdata, held);
		check_resp("rresp", rresp, aos_map_pkg::resp_okay);
		if (awready || wready || arready)
			flag_protocol("a ready was high in the cycle of the R transfer");
		data = rdata;
		rready <= 1'b0;
	endtask

	task automatic read_and_compare(input sr_types_pkg::sr_addr_t addr);
		sr_types_pkg::sr_data_t got;
		axil_read(addr, got);
		check_data("rdata", got, model_read(addr));
	endtask

	// --------------------
	// Timeout
	// --------------------
	always @(posedge global_clk) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// --------------------
	// Test sequence
	// --------------------
	initial begin
		int                     app;
		int                     idx;
		int                     off_slot;
		sr_types_pkg::sr_data_t data;
		sr_types_pkg::sr_addr_t addr;

		lfsr_state      = 32'hab73_d3c8;
		cycle_count     = 0;
		data_errors     = 0;
		resp_errors     = 0;
		protocol_errors = 0;
		model_mask      = '1;
		for (int a = 0; a < aos_map_pkg::MAX_APPS; a++)
			for (int w = 0; w < NUM_WORDS; w++)
				model_words[a][w] = '0;

		awvalid <= 1'b0;
		awaddr  <= '0;
		wvalid  <= 1'b0;
		wdata   <= '0;
		wstrb   <= '0;
		bready  <= 1'b0;
		arvalid <= 1'b0;
		araddr  <= '0;
		rready  <= 1'b0;

		wait (rst_n === 1'b1);
		@(posedge global_clk);
		if (!awready || !wready || !arready)
			flag_protocol("readies were not all high after reset");
		if (bvalid || rvalid)
			flag_protocol("bvalid or rvalid was high after reset");

		// Reset values
		for (int a = 0; a < NUM_APPS; a++)
			for (int w = 0; w < NUM_WORDS; w++)
				read_and_compare(make_addr(1'b0, a, w));
		read_and_compare(make_addr(1'b1, 0, 0));

		// Random write and read-back pairs
		for (int n = 0; n < NUM_RAND; n++) begin
			app  = take_bits(2) % NUM_APPS;
			idx  = take_bits(2);
			data = take_bits(32);
			addr = make_addr(1'b0, app, idx);
			axil_write(addr, data);
			read_and_compare(addr);
		end

		// Disable one slot, then bring it back
		off_slot = take_bits(2) % NUM_APPS;
		data     = take_bits(32) & ~32'h0000_000f;
		data[NUM_APPS-1:0] = ~(NUM_APPS'(1) << off_slot);
		axil_write(make_addr(1'b1, 0, 0), data);
		axil_write(make_addr(1'b0, off_slot, take_bits(2)), take_bits(32));
		for (int w = 0; w < NUM_WORDS; w++)
			read_and_compare(make_addr(1'b0, off_slot, w));
		axil_write(make_addr(1'b1, 0, 0), 32'hffff_ffff);
		for (int w = 0; w < NUM_WORDS; w++)
			read_and_compare(make_addr(1'b0, off_slot, w));

		// Configuration indices, mask truncation
		for (int k = 0; k < NUM_WORDS; k++) begin
			axil_write(make_addr(1'b1, 0, k), take_bits(32));
			read_and_compare(make_addr(1'b1, 0, k));
		end
		for (int n = 0; n < 4; n++)
			read_and_compare(make_addr(1'b0, take_bits(2) % NUM_APPS, take_bits(2)));
		axil_write(make_addr(1'b1, 0, 0), 32'h0000_000f);
		read_and_compare(make_addr(1'b1, 0, 0));

		$display("Error counts: data %0d, resp %0d, protocol %0d",
		         data_errors, resp_errors, protocol_errors);
		if ((data_errors + resp_errors + protocol_errors) == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

/* tb_clock_gen.sv */
/*
 * Testbench clock and reset source
 * Free-running clock of PERIOD_NS, with rst_n held low for RESET_CYCLES
 * rising edges and released on a falling edge.
 */

`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 8
) (
	output logic global_clk,
	output logic rst_n
);

	initial begin
		global_clk = 1'b0;
		forever #(PERIOD_NS / 2) global_clk = ~global_clk;
	end

	// Release away from the rising edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge global_clk);
		@(negedge global_clk);
		rst_n = 1'b1;
	end

endmodule

/* aos_softreg_top.sv */
/*
 * Soft-register subsystem top level
 * Host AXI4-Lite port -> bridge -> router -> per-slot request pipe -> scratch
 * slot, with a response pipe back to the router. The configuration block
 * sits directly on the router and supplies the slot enable mask.
 */

`timescale 1ns/1ps

module aos_softreg_top #(
	parameter int NUM_APPS    = 4,
	parameter int PIPE_STAGES = 2
) (
	input  logic                     global_clk,
	input  logic                     rst_n,
	input  logic                     awvalid,
	input  logic [31:0]              awaddr,
	output logic                     awready,
	input  logic                     wvalid,
	input  logic [31:0]              wdata,
	input  logic [3:0]               wstrb,
	output logic                     wready,
	output logic                     bvalid,
	output aos_map_pkg::axi_resp_e   bresp,
	input  logic                     bready,
	input  logic                     arvalid,
	input  logic [31:0]              araddr,
	output logic                     arready,
	output logic                     rvalid,
	output logic [31:0]              rdata,
	output aos_map_pkg::axi_resp_e   rresp,
	input  logic                     rready
);

	// Bridge to router
	logic                     req_valid;
	sr_types_pkg::sr_op_e     req_op;
	sr_types_pkg::sr_addr_t   req_addr;
	sr_types_pkg::sr_data_t   req_wdata;
	logic                     resp_valid;
	sr_types_pkg::sr_data_t   resp_rdata;

	// Router fan-out
	logic                     cfg_req_valid;
	logic                     cfg_resp_valid;
	sr_types_pkg::sr_data_t   cfg_resp_rdata;
	aos_map_pkg::reg_idx_t    cfg_idx;
	logic [NUM_APPS-1:0]      en_mask;
	logic [NUM_APPS-1:0]      app_req_valid;
	sr_types_pkg::sr_op_e     app_req_op;
	sr_types_pkg::sr_addr_t   app_req_addr;
	sr_types_pkg::sr_data_t   app_req_wdata;
	wire  [NUM_APPS-1:0]      app_resp_valid;
	wire  sr_types_pkg::sr_data_t app_resp_rdata [NUM_APPS];

	axil_sr_bridge axil_sr_bridge_inst (
		.global_clk (global_clk),
		.rst_n      (rst_n),
		.awvalid    (awvalid),
		.awaddr     (awaddr),
		.awready    (awready),
		.wvalid     (wvalid),
		.wdata      (wdata),
		.wstrb      (wstrb),
		.wready     (wready),
		.bvalid     (bvalid),
		.bresp      (bresp),
		.bready     (bready),
		.arvalid    (arvalid),
		.araddr     (araddr),
		.arready    (arready),
		.rvalid     (rvalid),
		.rdata      (rdata),
		.rresp      (rresp),
		.rready     (rready),
		.req_valid  (req_valid),
		.req_op     (req_op),
		.req_addr   (req_addr),
		.req_wdata  (req_wdata),
		.resp_valid (resp_valid),
		.resp_rdata (resp_rdata)
	);

	sr_router #(
		.NUM_APPS (NUM_APPS)
	) sr_router_inst (
		.global_clk     (global_clk),
		.rst_n          (rst_n),
		.req_valid      (req_valid),
		.req_op         (req_op),
		.req_addr       (req_addr),
		.req_wdata      (req_wdata),
		.resp_valid     (resp_valid),
		.resp_rdata     (resp_rdata),
		.en_mask        (en_mask),
		.cfg_req_valid  (cfg_req_valid),
		.cfg_resp_valid (cfg_resp_valid),
		.cfg_resp_rdata (cfg_resp_rdata),
		.app_req_valid  (app_req_valid),
		.app_req_op     (app_req_op),
		.app_req_addr   (app_req_addr),
		.app_req_wdata  (app_req_wdata),
		.app_resp_valid (app_resp_valid),
		.app_resp_rdata (app_resp_rdata)
	);

	// --------------------
	// Configuration block
	// --------------------
	assign cfg_idx = app_req_addr[aos_map_pkg::REG_IDX_LSB +: aos_map_pkg::REG_IDX_W];

	sr_config_regs #(
		.NUM_APPS (NUM_APPS)
	) sr_config_regs_inst (
		.global_clk (global_clk),
		.rst_n      (rst_n),
		.req_valid  (cfg_req_valid),
		.req_op     (app_req_op),
		.req_idx    (cfg_idx),
		.req_wdata  (app_req_wdata),
		.resp_valid (cfg_resp_valid),
		.resp_rdata (cfg_resp_rdata),
		.en_mask    (en_mask)
	);

	// --------------------
	// Application slots
	// --------------------
	for (genvar i = 0; i < NUM_APPS; i++) begin : gen_slot
		logic                     slot_valid;
		sr_types_pkg::sr_op_e     slot_op;
		sr_types_pkg::sr_addr_t   slot_addr;
		sr_types_pkg::sr_data_t   slot_wdata;
		aos_map_pkg::reg_idx_t    slot_idx;
		logic                     slot_resp_valid;
		sr_types_pkg::sr_data_t   slot_resp_rdata;

		sr_pipe #(
			.STAGES (PIPE_STAGES)
		) req_pipe_inst (
			.global_clk (global_clk),
			.rst_n      (rst_n),
			.in_valid   (app_req_valid[i]),
			.in_op      (app_req_op),
			.in_addr    (app_req_addr),
			.in_data    (app_req_wdata),
			.out_valid  (slot_valid),
			.out_op     (slot_op),
			.out_addr   (slot_addr),
			.out_data   (slot_wdata)
		);

		assign slot_idx = slot_addr[aos_map_pkg::REG_IDX_LSB +: aos_map_pkg::REG_IDX_W];

		app_scratch app_scratch_inst (
			.global_clk (global_clk),
			.rst_n      (rst_n),
			.req_valid  (slot_valid),
			.req_op     (slot_op),
			.req_idx    (slot_idx),
			.req_wdata  (slot_wdata),
			.resp_valid (slot_resp_valid),
			.resp_rdata (slot_resp_rdata)
		);

		// Responses carry data only
		sr_pipe #(
			.STAGES (PIPE_STAGES)
		) resp_pipe_inst (
			.global_clk (global_clk),
			.rst_n      (rst_n),
			.in_valid   (slot_resp_valid),
			.in_op      (sr_types_pkg::sr_read),
			.in_addr    ('0),
			.in_data    (slot_resp_rdata),
			.out_valid  (app_resp_valid[i]),
			.out_op     (),
			.out_addr   (),
			.out_data   (app_resp_rdata[i])
		);
	end

endmodule

/* app_scratch.sv */
/*
 * Scratch register file standing in for one application
 * Four words, cleared on reset. Writes store on the request cycle and
 * reads answer one cycle after the request.
 */

`timescale 1ns/1ps

module app_scratch (
	input  logic                     global_clk,
	input  logic                     rst_n,
	input  logic                     req_valid,
	input  sr_types_pkg::sr_op_e     req_op,
	input  aos_map_pkg::reg_idx_t    req_idx,
	input  sr_types_pkg::sr_data_t   req_wdata,
	output logic                     resp_valid,
	output sr_types_pkg::sr_data_t   resp_rdata
);

	localparam int NUM_WORDS = 2 ** aos_map_pkg::REG_IDX_W;

	sr_types_pkg::sr_data_t words [NUM_WORDS];

	logic wr_en;
	logic rd_en;

	assign wr_en = req_valid && (req_op == sr_types_pkg::sr_write);
	assign rd_en = req_valid && (req_op == sr_types_pkg::sr_read);

	// Register file, whole word per write
	always_ff @(posedge global_clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int w = 0; w < NUM_WORDS; w++)
				words[w] <= '0;
		end else if (wr_en) begin
			words[req_idx] <= req_wdata;
		end
	end

	always_ff @(posedge global_clk or negedge rst_n) begin
		if (!rst_n)
			resp_valid <= 1'b0;
		else
			resp_valid <= rd_en;
	end

	always_ff @(posedge global_clk) begin
		if (rd_en)
			resp_rdata <= words[req_idx];
	end

endmodule

/* sr_config_regs.sv */
/*
 * Configuration registers of the soft-register space
 * Index 0 is the application enable mask, all slots on after reset.
 * Indices 1 to 3 read zero. Reads answer one cycle after the request.
 */

`timescale 1ns/1ps

module sr_config_regs #(
	parameter int NUM_APPS = 4
) (
	input  logic                     global_clk,
	input  logic                     rst_n,
	input  logic                     req_valid,
	input  sr_types_pkg::sr_op_e     req_op,
	input  aos_map_pkg::reg_idx_t    req_idx,
	input  sr_types_pkg::sr_data_t   req_wdata,
	output logic                     resp_valid,
	output sr_types_pkg::sr_data_t   resp_rdata,
	output logic [NUM_APPS-1:0]      en_mask
);

	logic wr_en;
	logic rd_en;

	assign wr_en = req_valid && (req_op == sr_types_pkg::sr_write);
	assign rd_en = req_valid && (req_op == sr_types_pkg::sr_read);

	always_ff @(posedge global_clk or negedge rst_n) begin
		if (!rst_n) begin
			en_mask    <= '1;
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= rd_en;
			// Only the low NUM_APPS bits are kept
			if (wr_en && (req_idx == '0))
				en_mask <= req_wdata[NUM_APPS-1:0];
		end
	end

	always_ff @(posedge global_clk) begin
		if (rd_en) begin
			if (req_idx == '0)
				resp_rdata <= sr_types_pkg::sr_data_t'(en_mask);
			else
				resp_rdata <= '0;
		end
	end

endmodule

/* sr_router.sv */
/*
 * Soft-register router
 * Steers each request to the configuration block or one application slot,
 * gated by the enable mask, and merges the single response that comes back.
 * Reads of disabled or absent slots get a zero answer one cycle later.
 */

`timescale 1ns/1ps

module sr_router #(
	parameter int NUM_APPS = 4
) (
	input  logic                     global_clk,
	input  logic                     rst_n,

	// From the bridge
	input  logic                     req_valid,
	input  sr_types_pkg::sr_op_e     req_op,
	input  sr_types_pkg::sr_addr_t   req_addr,
	input  sr_types_pkg::sr_data_t   req_wdata,
	output logic                     resp_valid,
	output sr_types_pkg::sr_data_t   resp_rdata,

	input  logic [NUM_APPS-1:0]      en_mask,

	// Configuration block
	output logic                     cfg_req_valid,
	input  logic                     cfg_resp_valid,
	input  sr_types_pkg::sr_data_t   cfg_resp_rdata,

	// Application slots, op/addr/data shared with the configuration block
	output logic [NUM_APPS-1:0]      app_req_valid,
	output sr_types_pkg::sr_op_e     app_req_op,
	output sr_types_pkg::sr_addr_t   app_req_addr,
	output sr_types_pkg::sr_data_t   app_req_wdata,
	input  logic [NUM_APPS-1:0]      app_resp_valid,
	input  sr_types_pkg::sr_data_t   app_resp_rdata [NUM_APPS]
);

	logic                                is_cfg;
	logic [aos_map_pkg::APP_SEL_W-1:0]   app_sel;
	logic [aos_map_pkg::MAX_APPS-1:0]    en_full;
	logic                                slot_hit;
	logic                                null_read;
	logic                                null_resp_q;

	// --------------------
	// Request decode
	// --------------------
	always_comb begin
		is_cfg  = req_addr[aos_map_pkg::CFG_SEL_BIT];
		app_sel = req_addr[aos_map_pkg::APP_SEL_LSB +: aos_map_pkg::APP_SEL_W];

		// Slots beyond NUM_APPS look disabled
		en_full                 = '0;
		en_full[NUM_APPS-1:0]   = en_mask;

		slot_hit      = req_valid && !is_cfg && en_full[app_sel];
		cfg_req_valid = req_valid && is_cfg;
		null_read     = req_valid && !is_cfg && !en_full[app_sel] &&
		                (req_op == sr_types_pkg::sr_read);

		for (int i = 0; i < NUM_APPS; i++)
			app_req_valid[i] = slot_hit && (int'(app_sel) == i);
	end

	assign app_req_op    = req_op;
	assign app_req_addr  = req_addr;
	assign app_req_wdata = req_wdata;

	// Stand-in answer for a slot that cannot reply
	always_ff @(posedge global_clk or negedge rst_n) begin
		if (!rst_n)
			null_resp_q <= 1'b0;
		else
			null_resp_q <= null_read;
	end

	// --------------------
	// Response merge
	// --------------------
	// At most one source is valid, so an OR of gated data is enough
	always_comb begin
		resp_valid = null_resp_q || cfg_resp_valid;
		resp_rdata = cfg_resp_valid ? cfg_resp_rdata : '0;
		for (int i = 0; i < NUM_APPS; i++) begin
			resp_valid = resp_valid || app_resp_valid[i];
			if (app_resp_valid[i])
				resp_rdata = resp_rdata | app_resp_rdata[i];
		end
	end

endmodule

/* sr_pipe.sv */
/*
 * Register pipeline for soft-register requests or responses
 * Output is the input delayed by STAGES cycles; several items may be in flight.
 */

`timescale 1ns/1ps

module sr_pipe #(
	parameter int STAGES = 2
) (
	input  logic                     global_clk,
	input  logic                     rst_n,
	input  logic                     in_valid,
	input  sr_types_pkg::sr_op_e     in_op,
	input  sr_types_pkg::sr_addr_t   in_addr,
	input  sr_types_pkg::sr_data_t   in_data,
	output logic                     out_valid,
	output sr_types_pkg::sr_op_e     out_op,
	output sr_types_pkg::sr_addr_t   out_addr,
	output sr_types_pkg::sr_data_t   out_data
);

	logic [STAGES-1:0]       valid_q;
	sr_types_pkg::sr_op_e    op_q   [STAGES];
	sr_types_pkg::sr_addr_t  addr_q [STAGES];
	sr_types_pkg::sr_data_t  data_q [STAGES];

	always_ff @(posedge global_clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else begin
			valid_q[0] <= in_valid;
			for (int s = 1; s < STAGES; s++)
				valid_q[s] <= valid_q[s-1];
		end
	end

	// Payload shifts alongside its valid flag
	always_ff @(posedge global_clk) begin
		op_q[0]   <= in_op;
		addr_q[0] <= in_addr;
		data_q[0] <= in_data;
		for (int s = 1; s < STAGES; s++) begin
			op_q[s]   <= op_q[s-1];
			addr_q[s] <= addr_q[s-1];
			data_q[s] <= data_q[s-1];
		end
	end

	assign out_valid = valid_q[STAGES-1];
	assign out_op    = op_q[STAGES-1];
	assign out_addr  = addr_q[STAGES-1];
	assign out_data  = data_q[STAGES-1];

endmodule

/* axil_sr_bridge.sv */
/*
 * AXI4-Lite slave in front of the soft-register path
 * Collects AW and W in any order, or AR, issues one soft-register request and
 * holds the B or R response until the host takes it. One access at a time.
 */

`timescale 1ns/1ps

module axil_sr_bridge (
	input  logic                     global_clk,
	input  logic                     rst_n,

	// AXI4-Lite slave
	input  logic                     awvalid,
	input  logic [31:0]              awaddr,
	output logic                     awready,
	input  logic                     wvalid,
	input  logic [31:0]              wdata,
	input  logic [3:0]               wstrb,
	output logic                     wready,
	output logic                     bvalid,
	output aos_map_pkg::axi_resp_e   bresp,
	input  logic                     bready,
	input  logic                     arvalid,
	input  logic [31:0]              araddr,
	output logic                     arready,
	output logic                     rvalid,
	output logic [31:0]              rdata,
	output aos_map_pkg::axi_resp_e   rresp,
	input  logic                     rready,

	// Soft-register side
	output logic                     req_valid,
	output sr_types_pkg::sr_op_e     req_op,
	output sr_types_pkg::sr_addr_t   req_addr,
	output sr_types_pkg::sr_data_t   req_wdata,
	input  logic                     resp_valid,
	input  sr_types_pkg::sr_data_t   resp_rdata
);

	typedef enum logic [2:0] {
		st_idle,
		st_wr_collect,
		st_wr_resp,
		st_rd_wait,
		st_rd_resp
	} state_e;

	state_e state;

	// Which half of a write has already been taken
	logic aw_done;
	logic w_done;

	logic aw_fire;
	logic w_fire;
	logic ar_fire;
	logic wr_both;

	// --------------------
	// Handshakes
	// --------------------
	always_comb begin
		awready = (state == st_idle) || ((state == st_wr_collect) && !aw_done);
		wready  = (state == st_idle) || ((state == st_wr_collect) && !w_done);
		// A write starting in the same cycle wins over a read
		arready = (state == st_idle) && !awvalid && !wvalid;
	end

	assign aw_fire = awvalid && awready;
	assign w_fire  = wvalid && wready;
	assign ar_fire = arvalid && arready;
	assign wr_both = (aw_fire || aw_done) && (w_fire || w_done);

	// --------------------
	// Access FSM
	// --------------------
	always_ff @(posedge global_clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= st_idle;
			aw_done   <= 1'b0;
			w_done    <= 1'b0;
			req_valid <= 1'b0;
			req_op    <= sr_types_pkg::sr_read;
		end else begin
			req_valid <= 1'b0;
			case (state)
				st_idle, st_wr_collect: begin
					if (ar_fire) begin
						req_valid <= 1'b1;
						req_op    <= sr_types_pkg::sr_read;
						state     <= st_rd_wait;
					end else if (wr_both) begin
						req_valid <= 1'b1;
						req_op    <= sr_types_pkg::sr_write;
						aw_done   <= 1'b0;
						w_done    <= 1'b0;
						state     <= st_wr_resp;
					end else if (aw_fire || w_fire) begin
						aw_done <= aw_done || aw_fire;
						w_done  <= w_done || w_fire;
						state   <= st_wr_collect;
					end
				end
				st_wr_resp: if (bready) state <= st_idle;
				st_rd_wait: if (resp_valid) state <= st_rd_resp;
				st_rd_resp: if (rready) state <= st_idle;
				default:    state <= st_idle;
			endcase
		end
	end

	// Address, write data and read data
	always_ff @(posedge global_clk) begin
		if (ar_fire)
			req_addr <= araddr;
		else if (aw_fire)
			req_addr <= awaddr;
		// Strobes are ignored, every write stores the whole word
		if (w_fire)
			req_wdata <= wdata;
		if ((state == st_rd_wait) && resp_valid)
			rdata <= resp_rdata;
	end

	assign bvalid = (state == st_wr_resp);
	assign rvalid = (state == st_rd_resp);
	assign bresp  = aos_map_pkg::resp_okay;
	assign rresp  = aos_map_pkg::resp_okay;

endmodule

/* aos_map_pkg.sv */
/*
 * Host address map for the soft-register space
 * Field positions for the slot number, register index and configuration select,
 * and the AXI response codes. Refer to items as aos_map_pkg::name.
 */

package aos_map_pkg;

	// --------------------
	// Address fields
	// --------------------
	localparam int REG_IDX_LSB = 2;
	localparam int REG_IDX_W   = 2;

	localparam int APP_SEL_LSB = 4;
	localparam int APP_SEL_W   = 2;

	// Set for the configuration block, clear for an application slot
	localparam int CFG_SEL_BIT = 6;

	// Slots the application field can reach
	localparam int MAX_APPS = 4;

	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// --------------------
	// AXI response codes
	// --------------------
	typedef enum logic [1:0] {
		resp_okay   = 2'b00,
		resp_exokay = 2'b01,
		resp_slverr = 2'b10,
		resp_decerr = 2'b11
	} axi_resp_e;

endpackage

/* sr_types_pkg.sv */
/*
 * Soft-register transport types
 * Shared by the AXI4-Lite bridge, router, pipes and every register block.
 * Refer to items as sr_types_pkg::name.
 */

package sr_types_pkg;

	// --------------------
	// Access kinds
	// --------------------
	typedef enum logic {
		sr_read  = 1'b0,
		sr_write = 1'b1
	} sr_op_e;

	// --------------------
	// Request and response fields
	// --------------------

	// Byte address as seen by the host
	typedef logic [31:0] sr_addr_t;

	// Narrowed to the AXI4-Lite data width
	typedef logic [31:0] sr_data_t;

endpackage
